/* glwe_ram_slice.sv */
/* One GRAM coefficient slice: row memory, read pipeline,
   modular accumulate adder and write-back with load collision flag */
`timescale 1ns/1ps

module glwe_ram_slice (
  input  logic                  clk,
  input  logic                  s_rst_n,

  input  logic                  wr_en_i,
  input  mmacc_pkg::gram_add_t  wr_add_i,
  input  mmacc_pkg::slice_row_t wr_data_i,

  input  logic                  rd_en_i,
  input  logic                  rd_acc_i,
  input  mmacc_pkg::gram_add_t  rd_add_i,
  input  mmacc_pkg::slice_row_t acc_data_i,

  output mmacc_pkg::slice_row_t rd_data_o,
  output logic                  rd_avail_o,
  output logic                  collision_o
);

  mmacc_pkg::slice_row_t mem [mmacc_pkg::GRAM_DEPTH];

  logic [mmacc_pkg::RAM_LATENCY-1:0] rd_vld_p;
  logic [mmacc_pkg::RAM_LATENCY-1:0] rd_acc_p;
  mmacc_pkg::gram_add_t              rd_add_p [mmacc_pkg::RAM_LATENCY];
  mmacc_pkg::slice_row_t             opd_p    [mmacc_pkg::RAM_LATENCY];
  mmacc_pkg::slice_row_t             data_p   [mmacc_pkg::RAM_LATENCY];

  logic                  wb_en;
  mmacc_pkg::gram_add_t  wb_add;
  mmacc_pkg::slice_row_t wb_data;
  mmacc_pkg::slice_row_t acc_sum;

  logic                  mem_wr_en;
  mmacc_pkg::gram_add_t  mem_wr_add;
  mmacc_pkg::slice_row_t mem_wr_data;

  // Per coefficient a + b mod q, both operands already below q
  function automatic mmacc_pkg::slice_row_t slice_mod_add(input mmacc_pkg::slice_row_t a,
                                                          input mmacc_pkg::slice_row_t b);
    mmacc_pkg::slice_row_t      res;
    mmacc_pkg::coef_t           ca;
    mmacc_pkg::coef_t           cb;
    logic [mmacc_pkg::COEF_W:0] sum;
    for (int c = 0; c < mmacc_pkg::SLICE_COEF; c++) begin
      ca  = a[c*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W];
      cb  = b[c*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W];
      sum = {1'b0, ca} + {1'b0, cb};
      if (sum >= {1'b0, mmacc_pkg::MOD_Q}) begin
        sum = sum - {1'b0, mmacc_pkg::MOD_Q};
      end
      res[c*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W] = sum[mmacc_pkg::COEF_W-1:0];
    end
    return res;
  endfunction

  // ----------------------------------------
  // Write port
  // ----------------------------------------
  // Accumulate write-back wins over a load
  assign mem_wr_en   = wb_en | wr_en_i;
  assign mem_wr_add  = wb_en ? wb_add  : wr_add_i;
  assign mem_wr_data = wb_en ? wb_data : wr_data_i;
  assign collision_o = wb_en & wr_en_i;

  always_ff @(posedge clk) begin
    if (mem_wr_en) begin
      mem[mem_wr_add] <= mem_wr_data;
    end
  end

  // ----------------------------------------
  // Read pipeline
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      rd_vld_p <= '0;
      rd_acc_p <= '0;
      wb_en    <= 1'b0;
    end else begin
      rd_vld_p <= {rd_vld_p[mmacc_pkg::RAM_LATENCY-2:0], rd_en_i};
      rd_acc_p <= {rd_acc_p[mmacc_pkg::RAM_LATENCY-2:0], rd_en_i & rd_acc_i};
      wb_en    <= rd_vld_p[mmacc_pkg::RAM_LATENCY-1] & rd_acc_p[mmacc_pkg::RAM_LATENCY-1];
    end
  end

  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      // Same-edge write is forwarded so the read sees the new row
      if (mem_wr_en && mem_wr_add == rd_add_i) begin
        data_p[0] <= mem_wr_data;
      end else begin
        data_p[0] <= mem[rd_add_i];
      end
    end
    rd_add_p[0] <= rd_add_i;
    opd_p[0]    <= acc_data_i;
    for (int i = 1; i < mmacc_pkg::RAM_LATENCY; i++) begin
      data_p[i]   <= data_p[i-1];
      rd_add_p[i] <= rd_add_p[i-1];
      opd_p[i]    <= opd_p[i-1];
    end
    wb_add  <= rd_add_p[mmacc_pkg::RAM_LATENCY-1];
    wb_data <= acc_sum;
  end

  assign acc_sum = slice_mod_add(data_p[mmacc_pkg::RAM_LATENCY-1],
                                 opd_p[mmacc_pkg::RAM_LATENCY-1]);

  // Only sample-extract reads leave the slice
  assign rd_data_o  = data_p[mmacc_pkg::RAM_LATENCY-1];
  assign rd_avail_o = rd_vld_p[mmacc_pkg::RAM_LATENCY-1] & ~rd_acc_p[mmacc_pkg::RAM_LATENCY-1];

  wb_add_in_range_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    wb_en |-> (int'(wb_add) < mmacc_pkg::GRAM_DEPTH))
    else $error("GRAM write-back address %0d out of range", wb_add);

endmodule

/* mmacc_main.sv */
/* GRAM multiply-accumulate core top: request controller,
   coefficient slices and sample-extract collector */
`timescale 1ns/1ps

module mmacc_main (
  input  logic                    clk,
  input  logic                    s_rst_n,

  // External load
  input  logic                    ldg_wr_en_i,
  input  mmacc_pkg::gram_add_t    ldg_wr_add_i,
  input  mmacc_pkg::row_t         ldg_wr_data_i,

  // NTT result to accumulate
  input  logic                    acc_avail_i,
  input  mmacc_pkg::gram_add_t    acc_add_i,
  input  mmacc_pkg::row_t         acc_data_i,

  // Sample extract
  input  logic                    sxt_req_i,
  input  mmacc_pkg::gram_add_t    sxt_add_i,

  output logic                    sxt_avail_o,
  output mmacc_pkg::row_t         sxt_data_o,
  output mmacc_pkg::mmacc_error_t error_o
);

  logic                           wr_en;
  mmacc_pkg::gram_add_t           wr_add;
  mmacc_pkg::row_t                wr_data;
  logic                           rd_en;
  logic                           rd_acc;
  mmacc_pkg::gram_add_t           rd_add;
  mmacc_pkg::row_t                acc_data;
  logic                           sxt_ovf;

  mmacc_pkg::row_t                slice_rd_data;
  logic [mmacc_pkg::SLICE_NB-1:0] slice_rd_avail;
  logic [mmacc_pkg::SLICE_NB-1:0] slice_collision;

  mmacc_req_ctrl u_req_ctrl (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .ldg_wr_en_i   (ldg_wr_en_i),
    .ldg_wr_add_i  (ldg_wr_add_i),
    .ldg_wr_data_i (ldg_wr_data_i),
    .acc_avail_i   (acc_avail_i),
    .acc_add_i     (acc_add_i),
    .acc_data_i    (acc_data_i),
    .sxt_req_i     (sxt_req_i),
    .sxt_add_i     (sxt_add_i),
    .wr_en_o       (wr_en),
    .wr_add_o      (wr_add),
    .wr_data_o     (wr_data),
    .rd_en_o       (rd_en),
    .rd_acc_o      (rd_acc),
    .rd_add_o      (rd_add),
    .acc_data_o    (acc_data),
    .sxt_ovf_o     (sxt_ovf)
  );

  // ----------------------------------------
  // GRAM slices, slice s holds coefficients 2s and 2s+1
  // ----------------------------------------
  for (genvar gi = 0; gi < mmacc_pkg::SLICE_NB; gi++) begin : gen_slice
    glwe_ram_slice u_slice (
      .clk         (clk),
      .s_rst_n     (s_rst_n),
      .wr_en_i     (wr_en),
      .wr_add_i    (wr_add),
      .wr_data_i   (wr_data[gi*mmacc_pkg::SLICE_W +: mmacc_pkg::SLICE_W]),
      .rd_en_i     (rd_en),
      .rd_acc_i    (rd_acc),
      .rd_add_i    (rd_add),
      .acc_data_i  (acc_data[gi*mmacc_pkg::SLICE_W +: mmacc_pkg::SLICE_W]),
      .rd_data_o   (slice_rd_data[gi*mmacc_pkg::SLICE_W +: mmacc_pkg::SLICE_W]),
      .rd_avail_o  (slice_rd_avail[gi]),
      .collision_o (slice_collision[gi])
    );
  end

  mmacc_sxt_collect u_sxt_collect (
    .clk         (clk),
    .s_rst_n     (s_rst_n),
    .rd_data_i   (slice_rd_data),
    .rd_avail_i  (slice_rd_avail),
    .collision_i (slice_collision),
    .sxt_ovf_i   (sxt_ovf),
    .sxt_data_o  (sxt_data_o),
    .sxt_avail_o (sxt_avail_o),
    .error_o     (error_o)
  );

endmodule

/* mmacc_pkg.sv */
/* Shared constants and vector types of the GRAM multiply-accumulate core
   Row layout, slice split and error bit positions */
package mmacc_pkg;

  // ----------------------------------------
  // Coefficient arithmetic
  // ----------------------------------------
  localparam int COEF_W = 14;
  // Every stored coefficient stays below q
  localparam logic [COEF_W-1:0] MOD_Q = 14'd12289;

  // ----------------------------------------
  // GRAM geometry
  // ----------------------------------------
  localparam int SLICE_NB    = 3;
  localparam int SLICE_COEF  = 2;
  localparam int COEF_NB     = SLICE_NB * SLICE_COEF;
  localparam int SLICE_W     = SLICE_COEF * COEF_W;
  localparam int ROW_W       = COEF_NB * COEF_W;
  localparam int GRAM_DEPTH  = 16;
  localparam int GRAM_ADD_W  = $clog2(GRAM_DEPTH);
  localparam int RAM_LATENCY = 2;

  // Error vector bit positions
  localparam int ERR_GRAM_ACS = 0;
  localparam int ERR_SXT_OVF  = 1;
  localparam int ERR_W        = 2;

  // ----------------------------------------
  // Types
  // ----------------------------------------
  typedef logic [COEF_W-1:0]     coef_t;
  typedef logic [GRAM_ADD_W-1:0] gram_add_t;

  // Coefficient k of a row sits at bit k*COEF_W
  typedef logic [SLICE_W-1:0]    slice_row_t;
  typedef logic [ROW_W-1:0]      row_t;

  typedef logic [ERR_W-1:0]      mmacc_error_t;

endpackage

/* mmacc_req_ctrl.sv */
/* Request controller: registers load writes and accumulate reads,
   holds one waiting sample-extract request and flags its overflow */
`timescale 1ns/1ps

module mmacc_req_ctrl (
  input  logic                 clk,
  input  logic                 s_rst_n,

  input  logic                 ldg_wr_en_i,
  input  mmacc_pkg::gram_add_t ldg_wr_add_i,
  input  mmacc_pkg::row_t      ldg_wr_data_i,

  input  logic                 acc_avail_i,
  input  mmacc_pkg::gram_add_t acc_add_i,
  input  mmacc_pkg::row_t      acc_data_i,

  input  logic                 sxt_req_i,
  input  mmacc_pkg::gram_add_t sxt_add_i,

  output logic                 wr_en_o,
  output mmacc_pkg::gram_add_t wr_add_o,
  output mmacc_pkg::row_t      wr_data_o,

  output logic                 rd_en_o,
  output logic                 rd_acc_o,
  output mmacc_pkg::gram_add_t rd_add_o,
  output mmacc_pkg::row_t      acc_data_o,

  output logic                 sxt_ovf_o
);

  logic                 pend_vld;
  mmacc_pkg::gram_add_t pend_add;
  logic                 pend_issue;
  logic                 pend_load;
  logic                 sxt_direct;

  // ----------------------------------------
  // Read port ordering
  // ----------------------------------------
  // Accumulate always owns the port; a pending request drains when it is free
  assign pend_issue = pend_vld & ~acc_avail_i;
  assign sxt_direct = sxt_req_i & ~acc_avail_i & ~pend_vld;
  // No room: pending full and the port taken by an accumulate
  assign sxt_ovf_o  = sxt_req_i & pend_vld & acc_avail_i;
  assign pend_load  = sxt_req_i & ~sxt_ovf_o & (acc_avail_i | pend_vld);

  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      pend_vld <= 1'b0;
    end else if (pend_load) begin
      pend_vld <= 1'b1;
    end else if (pend_issue) begin
      pend_vld <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (pend_load) begin
      pend_add <= sxt_add_i;
    end
  end

  // ----------------------------------------
  // Slice commands
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      wr_en_o  <= 1'b0;
      rd_en_o  <= 1'b0;
      rd_acc_o <= 1'b0;
    end else begin
      wr_en_o  <= ldg_wr_en_i;
      rd_en_o  <= acc_avail_i | pend_issue | sxt_direct;
      rd_acc_o <= acc_avail_i;
    end
  end

  always_ff @(posedge clk) begin
    wr_add_o  <= ldg_wr_add_i;
    wr_data_o <= ldg_wr_data_i;
    if (acc_avail_i) begin
      rd_add_o   <= acc_add_i;
      acc_data_o <= acc_data_i;
    end else if (pend_issue) begin
      rd_add_o <= pend_add;
    end else begin
      rd_add_o <= sxt_add_i;
    end
  end

  // Sample extract never takes the slot of an accumulate
  sxt_not_with_acc_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    (pend_issue || sxt_direct) |-> !acc_avail_i)
    else $error("Sample-extract read issued together with an accumulate read");

endmodule

/* mmacc_sxt_collect.sv */
/* Sample-extract collector: registers assembled rows from the slices
   and merges slice collisions and request overflow into the error vector */
`timescale 1ns/1ps

module mmacc_sxt_collect (
  input  logic                            clk,
  input  logic                            s_rst_n,

  input  mmacc_pkg::row_t                 rd_data_i,
  input  logic [mmacc_pkg::SLICE_NB-1:0]  rd_avail_i,
  input  logic [mmacc_pkg::SLICE_NB-1:0]  collision_i,
  input  logic                            sxt_ovf_i,

  output mmacc_pkg::row_t                 sxt_data_o,
  output logic                            sxt_avail_o,
  output mmacc_pkg::mmacc_error_t         error_o
);

  mmacc_pkg::mmacc_error_t error_d;
  logic                    row_avail;

  // Slices run in lockstep
  assign row_avail = rd_avail_i[0];

  always_comb begin
    error_d                          = '0;
    error_d[mmacc_pkg::ERR_GRAM_ACS] = |collision_i;
    error_d[mmacc_pkg::ERR_SXT_OVF]  = sxt_ovf_i;
  end

  // ----------------------------------------
  // Output registers
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (!s_rst_n) begin
      sxt_avail_o <= 1'b0;
      error_o     <= '0;
    end else begin
      sxt_avail_o <= row_avail;
      error_o     <= error_d;
    end
  end

  always_ff @(posedge clk) begin
    if (row_avail) begin
      sxt_data_o <= rd_data_i;
    end
  end

  slices_in_step_a: assert property (@(posedge clk) disable iff (!s_rst_n)
    (rd_avail_i == '0) || (rd_avail_i == '1))
    else $error("Slice read data out of step: %b", rd_avail_i);

endmodule

/* project.f */
+incdir+.
mmacc_pkg.sv
glwe_ram_slice.sv
mmacc_req_ctrl.sv
mmacc_sxt_collect.sv
mmacc_main.sv
tb_mmacc_main.sv

/* run.sh */
#!/bin/sh
# Build and run the GRAM core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -sv -f project.f \
  --top-module tb_mmacc_main -Mdir obj_dir -o sim_mmacc
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

./obj_dir/sim_mmacc > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TB FAILED" "$LOG"; then
  echo "Simulation reported a failure"
  exit 1
fi

echo "Simulation finished without failure"
exit 0

/* tb_mmacc_tasks.svh */
/* Directed tests: load, accumulate and sample-extract drivers,
   and one task per checked behavior of the GRAM core */

  // ----------------------------------------
  // Request drivers
  // ----------------------------------------
  task automatic load_row(input mmacc_pkg::gram_add_t add, input mmacc_pkg::row_t data);
    ldg_wr_en_i   = 1'b1;
    ldg_wr_add_i  = add;
    ldg_wr_data_i = data;
    model[add]    = data;
    step();
    ldg_wr_en_i   = 1'b0;
  endtask

  task automatic acc_row(input mmacc_pkg::gram_add_t add, input mmacc_pkg::row_t opd);
    acc_avail_i = 1'b1;
    acc_add_i   = add;
    acc_data_i  = opd;
    model[add]  = mod_add_row(model[add], opd);
    step();
    acc_avail_i = 1'b0;
  endtask

  task automatic sxt_read(input mmacc_pkg::gram_add_t add, input string name,
                          input int exp_lat);
    sxt_req_i = 1'b1;
    sxt_add_i = add;
    step();
    sxt_req_i = 1'b0;
    collect_row(name, model[add], exp_lat);
  endtask

  // ----------------------------------------
  // Behavior tests
  // ----------------------------------------
  task automatic test_load_read();
    for (int a = 0; a < mmacc_pkg::GRAM_DEPTH; a++) begin
      load_row(mmacc_pkg::gram_add_t'(a), rand_row());
    end
    for (int a = 0; a < mmacc_pkg::GRAM_DEPTH; a++) begin
      sxt_read(mmacc_pkg::gram_add_t'(a), "test_load_read", 4);
    end
  endtask

  task automatic test_accumulate();
    err_seen = '0;
    // Back to back on distinct rows 1, 4, 7, 10, 13
    for (int i = 0; i < 5; i++) begin
      acc_row(mmacc_pkg::gram_add_t'(3*i + 1), rand_row());
    end
    drain(4);
    for (int i = 0; i < 5; i++) begin
      sxt_read(mmacc_pkg::gram_add_t'(3*i + 1), "test_accumulate", 4);
    end
    check_error("test_accumulate", '0, err_seen);
  endtask

  task automatic test_wrap();
    mmacc_pkg::row_t near;
    mmacc_pkg::row_t op1;
    mmacc_pkg::row_t op2;
    for (int k = 0; k < mmacc_pkg::COEF_NB; k++) begin
      near[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W] =
        mmacc_pkg::MOD_Q - mmacc_pkg::coef_t'(1 + k);
      op1[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W]  =
        mmacc_pkg::MOD_Q - mmacc_pkg::coef_t'(2 + 3*k);
      op2[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W]  =
        mmacc_pkg::MOD_Q - mmacc_pkg::coef_t'(100 + 7*k);
    end
    load_row(4'd5, near);
    acc_row(4'd5, op1);
    // Second strobe lands 4 cycles after the first
    drain(3);
    acc_row(4'd5, op2);
    drain(4);
    sxt_read(4'd5, "test_wrap", 4);
  endtask

  task automatic test_sxt_contention();
    mmacc_pkg::row_t opd;
    mmacc_pkg::row_t exp_row;
    err_seen    = '0;
    opd         = rand_row();
    exp_row     = model[8];
    acc_avail_i = 1'b1;
    acc_add_i   = 4'd2;
    acc_data_i  = opd;
    sxt_req_i   = 1'b1;
    sxt_add_i   = 4'd8;
    model[2]    = mod_add_row(model[2], opd);
    step();
    acc_avail_i = 1'b0;
    sxt_req_i   = 1'b0;
    collect_row("test_sxt_contention", exp_row, 0);
    drain(4);
    sxt_read(4'd2, "test_sxt_contention", 4);
    check_error("test_sxt_contention", '0, err_seen);
  endtask

  task automatic test_write_collision();
    mmacc_pkg::mmacc_error_t exp_err;
    exp_err                          = '0;
    exp_err[mmacc_pkg::ERR_GRAM_ACS] = 1'b1;
    err_seen                         = '0;
    acc_row(4'd3, rand_row());
    drain(2);
    // Load lands on the write-back edge and is dropped, so the model keeps row 11
    ldg_wr_en_i   = 1'b1;
    ldg_wr_add_i  = 4'd11;
    ldg_wr_data_i = rand_row();
    step();
    ldg_wr_en_i   = 1'b0;
    wait_error("test_write_collision", exp_err);
    drain(2);
    check_error("test_write_collision", exp_err, err_seen);
    sxt_read(4'd11, "test_write_collision", 4);
    sxt_read(4'd3, "test_write_collision", 4);
  endtask

  task automatic test_sxt_overflow();
    mmacc_pkg::mmacc_error_t exp_err;
    mmacc_pkg::row_t         opd;
    mmacc_pkg::row_t         exp_row;
    int                      avail_start;
    exp_err                         = '0;
    exp_err[mmacc_pkg::ERR_SXT_OVF] = 1'b1;
    err_seen                        = '0;
    avail_start                     = avail_cnt;
    exp_row                         = model[0];
    // First request waits in the pending slot, the next two overflow
    for (int i = 0; i < 3; i++) begin
      opd          = rand_row();
      acc_avail_i  = 1'b1;
      acc_add_i    = mmacc_pkg::gram_add_t'(12 + i);
      acc_data_i   = opd;
      model[12 + i] = mod_add_row(model[12 + i], opd);
      sxt_req_i    = 1'b1;
      sxt_add_i    = mmacc_pkg::gram_add_t'(i);
      step();
    end
    acc_avail_i = 1'b0;
    sxt_req_i   = 1'b0;
    wait_error("test_sxt_overflow", exp_err);
    collect_row("test_sxt_overflow", exp_row, 0);
    drain(6);
    if (avail_cnt != avail_start + 1) begin
      err_cnt++;
      $display("test_sxt_overflow returned %0d rows where exactly one was expected",
               avail_cnt - avail_start);
    end
    check_error("test_sxt_overflow", exp_err, err_seen);
    for (int i = 0; i < 3; i++) begin
      sxt_read(mmacc_pkg::gram_add_t'(12 + i), "test_sxt_overflow", 4);
    end
  endtask

/* tb_mmacc_main.sv */
/* Testbench top for the GRAM multiply-accumulate core
   Clock, reset, LFSR stimulus, reference row model and compare tasks */
`timescale 1ns/1ps

module tb_mmacc_main;

  localparam int SXT_TIMEOUT = 20;
  localparam int ERR_TIMEOUT = 10;

  logic                    clk;
  logic                    s_rst_n;
  logic                    ldg_wr_en_i;
  mmacc_pkg::gram_add_t    ldg_wr_add_i;
  mmacc_pkg::row_t         ldg_wr_data_i;
  logic                    acc_avail_i;
  mmacc_pkg::gram_add_t    acc_add_i;
  mmacc_pkg::row_t         acc_data_i;
  logic                    sxt_req_i;
  mmacc_pkg::gram_add_t    sxt_add_i;
  logic                    sxt_avail_o;
  mmacc_pkg::row_t         sxt_data_o;
  mmacc_pkg::mmacc_error_t error_o;

  // Mirror of the GRAM contents
  mmacc_pkg::row_t         model [mmacc_pkg::GRAM_DEPTH];
  logic [15:0]             lfsr_st;
  int                      err_cnt;
  int                      tmo_cnt;
  int                      avail_cnt;
  mmacc_pkg::mmacc_error_t err_seen;

  mmacc_main uut (
    .clk           (clk),
    .s_rst_n       (s_rst_n),
    .ldg_wr_en_i   (ldg_wr_en_i),
    .ldg_wr_add_i  (ldg_wr_add_i),
    .ldg_wr_data_i (ldg_wr_data_i),
    .acc_avail_i   (acc_avail_i),
    .acc_add_i     (acc_add_i),
    .acc_data_i    (acc_data_i),
    .sxt_req_i     (sxt_req_i),
    .sxt_add_i     (sxt_add_i),
    .sxt_avail_o   (sxt_avail_o),
    .sxt_data_o    (sxt_data_o),
    .error_o       (error_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ----------------------------------------
  // Random data
  // ----------------------------------------
  // Taps 16, 14, 13, 11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_st = lfsr_next(lfsr_st);
      r       = {r[30:0], lfsr_st[0]};
    end
    return r;
  endfunction

  function automatic mmacc_pkg::coef_t rand_coef();
    logic [31:0] r;
    r = rand_bits(mmacc_pkg::COEF_W);
    return mmacc_pkg::coef_t'(r % 32'(mmacc_pkg::MOD_Q));
  endfunction

  function automatic mmacc_pkg::row_t rand_row();
    mmacc_pkg::row_t r;
    for (int k = 0; k < mmacc_pkg::COEF_NB; k++) begin
      r[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W] = rand_coef();
    end
    return r;
  endfunction

  // Reference accumulate, every coefficient taken modulo q
  function automatic mmacc_pkg::row_t mod_add_row(input mmacc_pkg::row_t a,
                                                  input mmacc_pkg::row_t b);
    mmacc_pkg::row_t r;
    int              s;
    for (int k = 0; k < mmacc_pkg::COEF_NB; k++) begin
      s = int'(a[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W])
        + int'(b[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W]);
      s = s % int'(mmacc_pkg::MOD_Q);
      r[k*mmacc_pkg::COEF_W +: mmacc_pkg::COEF_W] = mmacc_pkg::coef_t'(s);
    end
    return r;
  endfunction

  // ----------------------------------------
  // Clock stepping and checks
  // ----------------------------------------
  // Advance to 1 ns after the next rising edge, track error and row pulses
  task automatic step();
    @(posedge clk);
    #1;
    err_seen = err_seen | error_o;
    if (sxt_avail_o) begin
      avail_cnt++;
    end
  endtask

  task automatic drain(input int n);
    repeat (n) step();
  endtask

  task automatic check_row(input string name, input mmacc_pkg::row_t exp_v,
                           input mmacc_pkg::row_t act_v);
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERR %s: expected %h actual %h", name, exp_v, act_v);
    end
  endtask

  task automatic check_error(input string name, input mmacc_pkg::mmacc_error_t exp_v,
                             input mmacc_pkg::mmacc_error_t act_v);
    if (act_v !== exp_v) begin
      err_cnt++;
      $display("ERR %s: expected error %b actual error %b", name, exp_v, act_v);
    end
  endtask

  // Called one step after the request edge; exp_lat of 0 skips the latency check
  task automatic collect_row(input string name, input mmacc_pkg::row_t exp_row,
                             input int exp_lat);
    int cycles;
    cycles = 1;
    while (!sxt_avail_o && cycles < SXT_TIMEOUT) begin
      step();
      cycles++;
    end
    if (!sxt_avail_o) begin
      tmo_cnt++;
      $display("Timeout in %s: no sample-extract row after %0d cycles", name, cycles);
    end else begin
      check_row(name, exp_row, sxt_data_o);
      if (exp_lat != 0 && cycles != exp_lat) begin
        err_cnt++;
        $display("Sample-extract latency in %s was %0d cycles instead of %0d",
                 name, cycles, exp_lat);
      end
      step();
    end
  endtask

  task automatic wait_error(input string name, input mmacc_pkg::mmacc_error_t mask);
    int cycles;
    cycles = 0;
    while ((err_seen & mask) == '0 && cycles < ERR_TIMEOUT) begin
      step();
      cycles++;
    end
    if ((err_seen & mask) == '0) begin
      tmo_cnt++;
      $display("Timeout in %s: error_o never raised the expected flag", name);
    end
  endtask

  `include "tb_mmacc_tasks.svh"

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    s_rst_n       = 1'b0;
    ldg_wr_en_i   = 1'b0;
    ldg_wr_add_i  = '0;
    ldg_wr_data_i = '0;
    acc_avail_i   = 1'b0;
    acc_add_i     = '0;
    acc_data_i    = '0;
    sxt_req_i     = 1'b0;
    sxt_add_i     = '0;
    lfsr_st       = 16'd17;
    err_cnt       = 0;
    tmo_cnt       = 0;
    avail_cnt     = 0;
    err_seen      = '0;

    repeat (2) @(posedge clk);
    #1;
    s_rst_n = 1'b1;
    drain(2);

    test_load_read();
    test_accumulate();
    test_wrap();
    test_sxt_contention();
    test_write_collision();
    test_sxt_overflow();

    $display("Checks done: %0d errors, %0d timeouts", err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule
